// File: hw/sdr_link_pkg.sv
package sdr_link_pkg;

  // Number of tile columns along the south edge.
  localparam int NUM_TILES = 4;

  // Packet widths for the request and response channels.
  localparam int FWD_WIDTH = 40;
  localparam int REV_WIDTH = 36;

  // The receiver FIFO holds 2^LG_FIFO_DEPTH entries.
  // The sender starts with the same number of credits.
  localparam int LG_FIFO_DEPTH = 3;
  localparam int FIFO_DEPTH    = 1 << LG_FIFO_DEPTH;

  // One token returns 2^LG_DECIMATION credits.
  localparam int LG_DECIMATION = 1;
  localparam int TOKEN_CREDITS = 1 << LG_DECIMATION;

  // Bit positions in the link reset bundle.
  // Bit 1 (downlink) and bit 3 (token) are only relayed.
  // They are reserved for the far side.
  localparam int LINK_RST_UPLINK     = 0;
  localparam int LINK_RST_DOWNSTREAM = 2;

  typedef logic [FWD_WIDTH-1:0] fwd_pkt_t;
  typedef logic [REV_WIDTH-1:0] rev_pkt_t;

  // Wide enough to hold a full FIFO worth of credit.
  typedef logic [LG_FIFO_DEPTH:0] credit_t;

  // FIFO pointers carry one wrap bit above the index.
  typedef logic [LG_FIFO_DEPTH:0] fifo_ptr_t;

  // Bit 0 uplink, bit 1 downlink, bit 2 downstream, bit 3 token.
  typedef logic [3:0] link_reset_t;

endpackage

// File: hw/sdr_credit_tx.sv
`timescale 1ns/10ps

module sdr_credit_tx #(
  parameter int WIDTH = sdr_link_pkg::FWD_WIDTH
) (
  input  logic             core_clk_i
  , input  logic             reset_i
  , input  logic             clear_i

  , input  logic             core_v_i
  , input  logic [WIDTH-1:0] core_data_i
  , output logic             core_ready_o

  , output logic             io_v_o
  , output logic [WIDTH-1:0] io_data_o
  , input  logic             io_token_i
);

  sdr_link_pkg::credit_t credit_q;
  sdr_link_pkg::credit_t credit_n;
  logic                  xfer;
  logic                  io_v_q;
  logic [WIDTH-1:0]      io_data_q;

  assign core_ready_o = (credit_q != '0);
  assign xfer         = core_v_i & core_ready_o;

  // A send and a returning token may land in the same cycle.
  always_comb begin
    credit_n = credit_q;
    if (xfer) begin
      credit_n = credit_n - sdr_link_pkg::credit_t'(1);
    end
    if (io_token_i) begin
      credit_n = credit_n + sdr_link_pkg::credit_t'(sdr_link_pkg::TOKEN_CREDITS);
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (reset_i || clear_i) begin
      credit_q <= sdr_link_pkg::credit_t'(sdr_link_pkg::FIFO_DEPTH);
      io_v_q   <= 1'b0;
    end else begin
      credit_q <= credit_n;
      io_v_q   <= xfer;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (xfer) begin
      io_data_q <= core_data_i;
    end
  end

  assign io_v_o    = io_v_q;
  assign io_data_o = io_data_q;

  // The far end only returns credit it was given, so the count never passes the FIFO depth.
  assert property (@(posedge core_clk_i) disable iff (reset_i || clear_i)
    io_token_i |=> (credit_q <= sdr_link_pkg::credit_t'(sdr_link_pkg::FIFO_DEPTH)));

endmodule

// File: hw/sdr_token_rx.sv
`timescale 1ns/10ps

module sdr_token_rx #(
  parameter int WIDTH = sdr_link_pkg::FWD_WIDTH
) (
  input  logic             core_clk_i
  , input  logic             reset_i
  , input  logic             clear_i

  , input  logic             io_v_i
  , input  logic [WIDTH-1:0] io_data_i
  , output logic             io_token_o

  , output logic             core_v_o
  , output logic [WIDTH-1:0] core_data_o
  , input  logic             core_yumi_i
);

  logic [WIDTH-1:0] mem_q [sdr_link_pkg::FIFO_DEPTH];

  sdr_link_pkg::fifo_ptr_t wr_ptr_q;
  sdr_link_pkg::fifo_ptr_t rd_ptr_q;
  sdr_link_pkg::fifo_ptr_t wr_ptr_n;
  sdr_link_pkg::fifo_ptr_t rd_ptr_n;
  sdr_link_pkg::fifo_ptr_t fill;
  logic                    full;
  logic                    valid_q;

  logic [sdr_link_pkg::LG_DECIMATION-1:0] dec_cnt_q;
  logic                                   token_q;

  // The wrap bit of the difference is set only when all entries are in use.
  assign fill = wr_ptr_q - rd_ptr_q;
  assign full = fill[sdr_link_pkg::LG_FIFO_DEPTH];

  always_comb begin
    wr_ptr_n = wr_ptr_q;
    rd_ptr_n = rd_ptr_q;
    if (io_v_i) begin
      wr_ptr_n = wr_ptr_q + sdr_link_pkg::fifo_ptr_t'(1);
    end
    if (core_yumi_i) begin
      rd_ptr_n = rd_ptr_q + sdr_link_pkg::fifo_ptr_t'(1);
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (reset_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      wr_ptr_q <= wr_ptr_n;
      rd_ptr_q <= rd_ptr_n;
      valid_q  <= (wr_ptr_n != rd_ptr_n);
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (io_v_i) begin
      mem_q[wr_ptr_q[sdr_link_pkg::LG_FIFO_DEPTH-1:0]] <= io_data_i;
    end
  end

  assign core_v_o    = valid_q;
  assign core_data_o = mem_q[rd_ptr_q[sdr_link_pkg::LG_FIFO_DEPTH-1:0]];

  // One token goes back for each full group of dequeues.
  always_ff @(posedge core_clk_i) begin
    if (reset_i || clear_i) begin
      dec_cnt_q <= '0;
      token_q   <= 1'b0;
    end else begin
      token_q <= core_yumi_i & (&dec_cnt_q);
      if (core_yumi_i) begin
        dec_cnt_q <= dec_cnt_q + 1'b1;
      end
    end
  end

  assign io_token_o = token_q;

  // The far-side sender holds credit for every entry, so it never writes into a full FIFO.
  assert property (@(posedge core_clk_i) disable iff (reset_i || clear_i)
    io_v_i |-> !full);

  // The core only takes an entry it has been shown.
  assert property (@(posedge core_clk_i) disable iff (reset_i || clear_i)
    core_yumi_i |-> core_v_o);

endmodule

// File: hw/sdr_link_tile.sv
`timescale 1ns/10ps

module sdr_link_tile (
  input  logic                      core_clk_i
  , input  logic                      reset_i

  , input  sdr_link_pkg::link_reset_t link_reset_i
  , output sdr_link_pkg::link_reset_t link_reset_o

  , input  logic                      core_fwd_v_i
  , input  sdr_link_pkg::fwd_pkt_t    core_fwd_data_i
  , output logic                      core_fwd_ready_o

  , output logic                      core_fwd_v_o
  , output sdr_link_pkg::fwd_pkt_t    core_fwd_data_o
  , input  logic                      core_fwd_yumi_i

  , input  logic                      core_rev_v_i
  , input  sdr_link_pkg::rev_pkt_t    core_rev_data_i
  , output logic                      core_rev_ready_o

  , output logic                      core_rev_v_o
  , output sdr_link_pkg::rev_pkt_t    core_rev_data_o
  , input  logic                      core_rev_yumi_i

  , output logic                      io_fwd_v_o
  , output sdr_link_pkg::fwd_pkt_t    io_fwd_data_o
  , input  logic                      io_fwd_token_i
  , input  logic                      io_fwd_v_i
  , input  sdr_link_pkg::fwd_pkt_t    io_fwd_data_i
  , output logic                      io_fwd_token_o

  , output logic                      io_rev_v_o
  , output sdr_link_pkg::rev_pkt_t    io_rev_data_o
  , input  logic                      io_rev_token_i
  , input  logic                      io_rev_v_i
  , input  sdr_link_pkg::rev_pkt_t    io_rev_data_i
  , output logic                      io_rev_token_o
);

  sdr_link_pkg::link_reset_t link_reset_q;
  logic                      uplink_clear;
  logic                      downstream_clear;

  // One relay stage per tile, so the chain latency equals the tile count.
  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      link_reset_q <= '0;
    end else begin
      link_reset_q <= link_reset_i;
    end
  end

  assign link_reset_o     = link_reset_q;
  assign uplink_clear     = link_reset_q[sdr_link_pkg::LINK_RST_UPLINK];
  assign downstream_clear = link_reset_q[sdr_link_pkg::LINK_RST_DOWNSTREAM];

  sdr_credit_tx #(.WIDTH(sdr_link_pkg::FWD_WIDTH)) i_fwd_tx (
    .core_clk_i    (core_clk_i)
    , .reset_i     (reset_i)
    , .clear_i     (uplink_clear)
    , .core_v_i    (core_fwd_v_i)
    , .core_data_i (core_fwd_data_i)
    , .core_ready_o(core_fwd_ready_o)
    , .io_v_o      (io_fwd_v_o)
    , .io_data_o   (io_fwd_data_o)
    , .io_token_i  (io_fwd_token_i)
  );

  sdr_token_rx #(.WIDTH(sdr_link_pkg::FWD_WIDTH)) i_fwd_rx (
    .core_clk_i    (core_clk_i)
    , .reset_i     (reset_i)
    , .clear_i     (downstream_clear)
    , .io_v_i      (io_fwd_v_i)
    , .io_data_i   (io_fwd_data_i)
    , .io_token_o  (io_fwd_token_o)
    , .core_v_o    (core_fwd_v_o)
    , .core_data_o (core_fwd_data_o)
    , .core_yumi_i (core_fwd_yumi_i)
  );

  sdr_credit_tx #(.WIDTH(sdr_link_pkg::REV_WIDTH)) i_rev_tx (
    .core_clk_i    (core_clk_i)
    , .reset_i     (reset_i)
    , .clear_i     (uplink_clear)
    , .core_v_i    (core_rev_v_i)
    , .core_data_i (core_rev_data_i)
    , .core_ready_o(core_rev_ready_o)
    , .io_v_o      (io_rev_v_o)
    , .io_data_o   (io_rev_data_o)
    , .io_token_i  (io_rev_token_i)
  );

  sdr_token_rx #(.WIDTH(sdr_link_pkg::REV_WIDTH)) i_rev_rx (
    .core_clk_i    (core_clk_i)
    , .reset_i     (reset_i)
    , .clear_i     (downstream_clear)
    , .io_v_i      (io_rev_v_i)
    , .io_data_i   (io_rev_data_i)
    , .io_token_o  (io_rev_token_o)
    , .core_v_o    (core_rev_v_o)
    , .core_data_o (core_rev_data_o)
    , .core_yumi_i (core_rev_yumi_i)
  );

endmodule

// File: hw/sdr_link_row.sv
`timescale 1ns/10ps

module sdr_link_row (
  input  logic                                               core_clk_i
  , input  logic                                               reset_i

  , input  sdr_link_pkg::link_reset_t                          reset_lines_i
  , output sdr_link_pkg::link_reset_t                          reset_lines_o

  , input  logic [sdr_link_pkg::NUM_TILES-1:0]                 core_fwd_v_i
  , input  sdr_link_pkg::fwd_pkt_t [sdr_link_pkg::NUM_TILES-1:0] core_fwd_data_i
  , output logic [sdr_link_pkg::NUM_TILES-1:0]                 core_fwd_ready_o

  , output logic [sdr_link_pkg::NUM_TILES-1:0]                 core_fwd_v_o
  , output sdr_link_pkg::fwd_pkt_t [sdr_link_pkg::NUM_TILES-1:0] core_fwd_data_o
  , input  logic [sdr_link_pkg::NUM_TILES-1:0]                 core_fwd_yumi_i

  , input  logic [sdr_link_pkg::NUM_TILES-1:0]                 core_rev_v_i
  , input  sdr_link_pkg::rev_pkt_t [sdr_link_pkg::NUM_TILES-1:0] core_rev_data_i
  , output logic [sdr_link_pkg::NUM_TILES-1:0]                 core_rev_ready_o

  , output logic [sdr_link_pkg::NUM_TILES-1:0]                 core_rev_v_o
  , output sdr_link_pkg::rev_pkt_t [sdr_link_pkg::NUM_TILES-1:0] core_rev_data_o
  , input  logic [sdr_link_pkg::NUM_TILES-1:0]                 core_rev_yumi_i

  , output logic [sdr_link_pkg::NUM_TILES-1:0]                 io_fwd_v_o
  , output sdr_link_pkg::fwd_pkt_t [sdr_link_pkg::NUM_TILES-1:0] io_fwd_data_o
  , input  logic [sdr_link_pkg::NUM_TILES-1:0]                 io_fwd_token_i
  , input  logic [sdr_link_pkg::NUM_TILES-1:0]                 io_fwd_v_i
  , input  sdr_link_pkg::fwd_pkt_t [sdr_link_pkg::NUM_TILES-1:0] io_fwd_data_i
  , output logic [sdr_link_pkg::NUM_TILES-1:0]                 io_fwd_token_o

  , output logic [sdr_link_pkg::NUM_TILES-1:0]                 io_rev_v_o
  , output sdr_link_pkg::rev_pkt_t [sdr_link_pkg::NUM_TILES-1:0] io_rev_data_o
  , input  logic [sdr_link_pkg::NUM_TILES-1:0]                 io_rev_token_i
  , input  logic [sdr_link_pkg::NUM_TILES-1:0]                 io_rev_v_i
  , input  sdr_link_pkg::rev_pkt_t [sdr_link_pkg::NUM_TILES-1:0] io_rev_data_i
  , output logic [sdr_link_pkg::NUM_TILES-1:0]                 io_rev_token_o
);

  sdr_link_pkg::link_reset_t link_reset_li [sdr_link_pkg::NUM_TILES];
  sdr_link_pkg::link_reset_t link_reset_lo [sdr_link_pkg::NUM_TILES];

  for (genvar x = 0; x < sdr_link_pkg::NUM_TILES; x++) begin : g_tile
    sdr_link_tile i_tile (
      .core_clk_i        (core_clk_i)
      , .reset_i         (reset_i)
      , .link_reset_i    (link_reset_li[x])
      , .link_reset_o    (link_reset_lo[x])
      , .core_fwd_v_i    (core_fwd_v_i[x])
      , .core_fwd_data_i (core_fwd_data_i[x])
      , .core_fwd_ready_o(core_fwd_ready_o[x])
      , .core_fwd_v_o    (core_fwd_v_o[x])
      , .core_fwd_data_o (core_fwd_data_o[x])
      , .core_fwd_yumi_i (core_fwd_yumi_i[x])
      , .core_rev_v_i    (core_rev_v_i[x])
      , .core_rev_data_i (core_rev_data_i[x])
      , .core_rev_ready_o(core_rev_ready_o[x])
      , .core_rev_v_o    (core_rev_v_o[x])
      , .core_rev_data_o (core_rev_data_o[x])
      , .core_rev_yumi_i (core_rev_yumi_i[x])
      , .io_fwd_v_o      (io_fwd_v_o[x])
      , .io_fwd_data_o   (io_fwd_data_o[x])
      , .io_fwd_token_i  (io_fwd_token_i[x])
      , .io_fwd_v_i      (io_fwd_v_i[x])
      , .io_fwd_data_i   (io_fwd_data_i[x])
      , .io_fwd_token_o  (io_fwd_token_o[x])
      , .io_rev_v_o      (io_rev_v_o[x])
      , .io_rev_data_o   (io_rev_data_o[x])
      , .io_rev_token_i  (io_rev_token_i[x])
      , .io_rev_v_i      (io_rev_v_i[x])
      , .io_rev_data_i   (io_rev_data_i[x])
      , .io_rev_token_o  (io_rev_token_o[x])
    );

    // Reset lines enter at the east end and travel west one tile per cycle.
    if (x == sdr_link_pkg::NUM_TILES-1) begin : g_east
      assign link_reset_li[x] = reset_lines_i;
    end else begin : g_chain
      assign link_reset_li[x] = link_reset_lo[x+1];
    end
  end

  assign reset_lines_o = link_reset_lo[0];

endmodule

// File: test/tb_sdr_link_row.sv
`timescale 1ns/10ps

module tb_sdr_link_row;

  logic core_clk = 1'b0;
  logic reset_i;
  sdr_link_pkg::link_reset_t reset_lines_i;
  sdr_link_pkg::link_reset_t reset_lines_o;

  logic [sdr_link_pkg::NUM_TILES-1:0] core_fwd_v_i;
  sdr_link_pkg::fwd_pkt_t [sdr_link_pkg::NUM_TILES-1:0] core_fwd_data_i;
  logic [sdr_link_pkg::NUM_TILES-1:0] core_fwd_ready_o;
  logic [sdr_link_pkg::NUM_TILES-1:0] core_fwd_v_o;
  sdr_link_pkg::fwd_pkt_t [sdr_link_pkg::NUM_TILES-1:0] core_fwd_data_o;
  logic [sdr_link_pkg::NUM_TILES-1:0] core_fwd_yumi_i;
  logic [sdr_link_pkg::NUM_TILES-1:0] core_rev_v_i;
  sdr_link_pkg::rev_pkt_t [sdr_link_pkg::NUM_TILES-1:0] core_rev_data_i;
  logic [sdr_link_pkg::NUM_TILES-1:0] core_rev_ready_o;
  logic [sdr_link_pkg::NUM_TILES-1:0] core_rev_v_o;
  sdr_link_pkg::rev_pkt_t [sdr_link_pkg::NUM_TILES-1:0] core_rev_data_o;
  logic [sdr_link_pkg::NUM_TILES-1:0] core_rev_yumi_i;

  // Each tile's link outputs feed its own link inputs.
  logic [sdr_link_pkg::NUM_TILES-1:0] io_fwd_v;
  sdr_link_pkg::fwd_pkt_t [sdr_link_pkg::NUM_TILES-1:0] io_fwd_data;
  logic [sdr_link_pkg::NUM_TILES-1:0] io_fwd_token;
  logic [sdr_link_pkg::NUM_TILES-1:0] io_rev_v;
  sdr_link_pkg::rev_pkt_t [sdr_link_pkg::NUM_TILES-1:0] io_rev_data;
  logic [sdr_link_pkg::NUM_TILES-1:0] io_rev_token;

  sdr_link_pkg::fwd_pkt_t fwd_q [sdr_link_pkg::NUM_TILES][$];
  sdr_link_pkg::rev_pkt_t rev_q [sdr_link_pkg::NUM_TILES][$];
  int sent_fwd [sdr_link_pkg::NUM_TILES];
  int sent_rev [sdr_link_pkg::NUM_TILES];
  int took_fwd [sdr_link_pkg::NUM_TILES];
  int took_rev [sdr_link_pkg::NUM_TILES];
  logic [sdr_link_pkg::NUM_TILES-1:0] fwd_xfer_exp = '0;
  logic [sdr_link_pkg::NUM_TILES-1:0] rev_xfer_exp = '0;
  logic [sdr_link_pkg::NUM_TILES-1:0] fwd_token_exp = '0;
  logic [sdr_link_pkg::NUM_TILES-1:0] rev_token_exp = '0;
  sdr_link_pkg::fwd_pkt_t fwd_last [sdr_link_pkg::NUM_TILES];
  sdr_link_pkg::rev_pkt_t rev_last [sdr_link_pkg::NUM_TILES];
  logic [15:0] lfsr = 16'd15;
  int errors = 0;
  int tests = 0;
  int failed = 0;

  always #2 core_clk = ~core_clk;

  sdr_link_row i_dut (
    .core_clk_i(core_clk), .reset_i(reset_i)
    , .reset_lines_i(reset_lines_i), .reset_lines_o(reset_lines_o)
    , .core_fwd_v_i(core_fwd_v_i), .core_fwd_data_i(core_fwd_data_i)
    , .core_fwd_ready_o(core_fwd_ready_o), .core_fwd_v_o(core_fwd_v_o)
    , .core_fwd_data_o(core_fwd_data_o), .core_fwd_yumi_i(core_fwd_yumi_i)
    , .core_rev_v_i(core_rev_v_i), .core_rev_data_i(core_rev_data_i)
    , .core_rev_ready_o(core_rev_ready_o), .core_rev_v_o(core_rev_v_o)
    , .core_rev_data_o(core_rev_data_o), .core_rev_yumi_i(core_rev_yumi_i)
    , .io_fwd_v_o(io_fwd_v), .io_fwd_data_o(io_fwd_data), .io_fwd_token_i(io_fwd_token)
    , .io_fwd_v_i(io_fwd_v), .io_fwd_data_i(io_fwd_data), .io_fwd_token_o(io_fwd_token)
    , .io_rev_v_o(io_rev_v), .io_rev_data_o(io_rev_data), .io_rev_token_i(io_rev_token)
    , .io_rev_v_i(io_rev_v), .io_rev_data_i(io_rev_data), .io_rev_token_o(io_rev_token)
  );

  // Taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // Mode 0 never, 1 at random, 2 always.
  function automatic logic decide(input logic [1:0] mode);
    if (mode == 2'd1) begin
      return rand_bits(1) != '0;
    end
    return mode == 2'd2;
  endfunction

  task automatic check_fwd(input string name, input sdr_link_pkg::fwd_pkt_t got,
                           input sdr_link_pkg::fwd_pkt_t exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_rev(input string name, input sdr_link_pkg::rev_pkt_t got,
                           input sdr_link_pkg::rev_pkt_t exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reset(input string name, input sdr_link_pkg::link_reset_t got,
                             input sdr_link_pkg::link_reset_t exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_credit(input string name, input sdr_link_pkg::credit_t got,
                              input sdr_link_pkg::credit_t exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // The link outputs answer the transfers and dequeues of the previous falling edge.
  task automatic check_link(input int t);
    check_bit($sformatf("io_fwd_v_o[%0d]", t), io_fwd_v[t], fwd_xfer_exp[t]);
    if (fwd_xfer_exp[t]) begin
      check_fwd($sformatf("io_fwd_data_o[%0d]", t), io_fwd_data[t], fwd_last[t]);
    end
    check_bit($sformatf("io_fwd_token_o[%0d]", t), io_fwd_token[t], fwd_token_exp[t]);
    check_bit($sformatf("io_rev_v_o[%0d]", t), io_rev_v[t], rev_xfer_exp[t]);
    if (rev_xfer_exp[t]) begin
      check_rev($sformatf("io_rev_data_o[%0d]", t), io_rev_data[t], rev_last[t]);
    end
    check_bit($sformatf("io_rev_token_o[%0d]", t), io_rev_token[t], rev_token_exp[t]);
  endtask

  // Each call covers one falling edge, where shown packets are taken and new ones offered.
  task automatic step(input logic [1:0] send_mode, input logic [1:0] take_mode);
    @(negedge core_clk);
    for (int t = 0; t < sdr_link_pkg::NUM_TILES; t++) begin
      check_link(t);
      core_fwd_yumi_i[t] = core_fwd_v_o[t] && decide(take_mode);
      if (core_fwd_yumi_i[t] && fwd_q[t].size() == 0) begin
        $display("tile %0d forward channel delivered a packet that was never sent", t);
        errors++;
      end else if (core_fwd_yumi_i[t]) begin
        check_fwd($sformatf("core_fwd_data_o[%0d]", t), core_fwd_data_o[t], fwd_q[t].pop_front());
      end
      fwd_token_exp[t] = core_fwd_yumi_i[t] &&
                         (took_fwd[t] % sdr_link_pkg::TOKEN_CREDITS ==
                          sdr_link_pkg::TOKEN_CREDITS - 1);
      if (core_fwd_yumi_i[t]) begin
        took_fwd[t]++;
      end
      core_rev_yumi_i[t] = core_rev_v_o[t] && decide(take_mode);
      if (core_rev_yumi_i[t] && rev_q[t].size() == 0) begin
        $display("tile %0d reverse channel delivered a packet that was never sent", t);
        errors++;
      end else if (core_rev_yumi_i[t]) begin
        check_rev($sformatf("core_rev_data_o[%0d]", t), core_rev_data_o[t], rev_q[t].pop_front());
      end
      rev_token_exp[t] = core_rev_yumi_i[t] &&
                         (took_rev[t] % sdr_link_pkg::TOKEN_CREDITS ==
                          sdr_link_pkg::TOKEN_CREDITS - 1);
      if (core_rev_yumi_i[t]) begin
        took_rev[t]++;
      end
      core_fwd_v_i[t] = decide(send_mode);
      core_fwd_data_i[t] = sdr_link_pkg::fwd_pkt_t'(rand_bits(sdr_link_pkg::FWD_WIDTH));
      fwd_xfer_exp[t] = core_fwd_v_i[t] && core_fwd_ready_o[t];
      fwd_last[t] = core_fwd_data_i[t];
      if (fwd_xfer_exp[t]) begin
        fwd_q[t].push_back(core_fwd_data_i[t]);
        sent_fwd[t]++;
      end
      core_rev_v_i[t] = decide(send_mode);
      core_rev_data_i[t] = sdr_link_pkg::rev_pkt_t'(rand_bits(sdr_link_pkg::REV_WIDTH));
      rev_xfer_exp[t] = core_rev_v_i[t] && core_rev_ready_o[t];
      rev_last[t] = core_rev_data_i[t];
      if (rev_xfer_exp[t]) begin
        rev_q[t].push_back(core_rev_data_i[t]);
        sent_rev[t]++;
      end
    end
  endtask

  function automatic logic queues_empty();
    logic empty;
    empty = 1'b1;
    for (int t = 0; t < sdr_link_pkg::NUM_TILES; t++) begin
      empty &= (fwd_q[t].size() == 0) && (rev_q[t].size() == 0);
    end
    return empty;
  endfunction

  task automatic clear_model();
    for (int t = 0; t < sdr_link_pkg::NUM_TILES; t++) begin
      fwd_q[t].delete();
      rev_q[t].delete();
      sent_fwd[t] = 0;
      sent_rev[t] = 0;
      took_fwd[t] = 0;
      took_rev[t] = 0;
    end
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    repeat (10) step(2'd0, 2'd0);
    reset_i = 1'b0;
    clear_model();
  endtask

  task automatic drain(input string what);
    int cnt;
    cnt = 0;
    while (!queues_empty() && cnt < 200) begin
      step(2'd0, 2'd2);
      cnt++;
    end
    if (!queues_empty()) begin
      $display("%s: packets still missing after the drain timeout", what);
      errors++;
    end
  endtask

  task automatic check_idle_state(input logic [1:0] mode);
    for (int t = 0; t < sdr_link_pkg::NUM_TILES; t++) begin
      check_bit($sformatf("core_fwd_ready_o[%0d]", t), core_fwd_ready_o[t], mode[0]);
      check_bit($sformatf("core_rev_ready_o[%0d]", t), core_rev_ready_o[t], mode[0]);
      if (mode[1]) begin
        check_bit($sformatf("core_fwd_v_o[%0d]", t), core_fwd_v_o[t], 1'b0);
        check_bit($sformatf("core_rev_v_o[%0d]", t), core_rev_v_o[t], 1'b0);
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    sdr_link_pkg::link_reset_t r;
    int e;
    int cnt;
    reset_lines_i = '0;
    core_fwd_v_i = '0;
    core_fwd_data_i = '0;
    core_fwd_yumi_i = '0;
    core_rev_v_i = '0;
    core_rev_data_i = '0;
    core_rev_yumi_i = '0;
    apply_reset();

    e = errors;
    step(2'd0, 2'd0);
    check_idle_state(2'b11);
    report_test("reset state", e);

    e = errors;
    repeat (400) step(2'd1, 2'd1);
    drain("random loopback");
    step(2'd0, 2'd0);
    check_idle_state(2'b11);
    report_test("random loopback", e);

    apply_reset();
    e = errors;
    cnt = 0;
    while (((|core_fwd_ready_o) || (|core_rev_ready_o)) && cnt < 50) begin
      step(2'd2, 2'd0);
      cnt++;
    end
    if ((|core_fwd_ready_o) || (|core_rev_ready_o)) begin
      $display("back-pressure: core_ready_o stayed high past the timeout");
      errors++;
    end
    repeat (4) step(2'd2, 2'd0);
    for (int t = 0; t < sdr_link_pkg::NUM_TILES; t++) begin
      check_credit($sformatf("fwd accepted count[%0d]", t), sdr_link_pkg::credit_t'(sent_fwd[t]),
                   sdr_link_pkg::credit_t'(sdr_link_pkg::FIFO_DEPTH));
      check_credit($sformatf("rev accepted count[%0d]", t), sdr_link_pkg::credit_t'(sent_rev[t]),
                   sdr_link_pkg::credit_t'(sdr_link_pkg::FIFO_DEPTH));
    end
    check_idle_state(2'b00);
    drain("back-pressure");
    cnt = 0;
    while (!((&core_fwd_ready_o) && (&core_rev_ready_o)) && cnt < 20) begin
      step(2'd0, 2'd0);
      cnt++;
    end
    if (!((&core_fwd_ready_o) && (&core_rev_ready_o))) begin
      $display("back-pressure: credit did not return after the drain");
      errors++;
    end
    report_test("back-pressure", e);

    e = errors;
    do begin
      r = sdr_link_pkg::link_reset_t'(rand_bits(4));
    end while (r == '0);
    step(2'd0, 2'd0);
    reset_lines_i = r;
    for (int k = 1; k <= sdr_link_pkg::NUM_TILES + 1; k++) begin
      step(2'd0, 2'd0);
      reset_lines_i = '0;
      check_reset("reset_lines_o", reset_lines_o, (k == sdr_link_pkg::NUM_TILES) ? r : '0);
    end
    // A downstream clear restarts the token grouping in every tile.
    if (r[sdr_link_pkg::LINK_RST_DOWNSTREAM]) begin
      clear_model();
    end
    report_test("reset relay", e);

    // Fill the FIFOs, let the link settle, then clear through the relay.
    e = errors;
    repeat (12) step(2'd1, 2'd0);
    repeat (4) step(2'd0, 2'd0);
    reset_lines_i = 4'b0101;
    step(2'd0, 2'd0);
    reset_lines_i = '0;
    repeat (sdr_link_pkg::NUM_TILES) step(2'd0, 2'd0);
    clear_model();
    check_idle_state(2'b11);
    repeat (60) step(2'd1, 2'd1);
    drain("relay clear");
    report_test("relay clear", e);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
hw/sdr_link_pkg.sv
hw/sdr_credit_tx.sv
hw/sdr_token_rx.sv
hw/sdr_link_tile.sv
hw/sdr_link_row.sv
test/tb_sdr_link_row.sv

// File: Bender.yml
package:
  name: sdr_link_row

sources:
  - hw/sdr_link_pkg.sv
  - hw/sdr_credit_tx.sv
  - hw/sdr_token_rx.sv
  - hw/sdr_link_tile.sv
  - hw/sdr_link_row.sv
  - target: test
    files:
      - test/tb_sdr_link_row.sv
